/* sim.f */
source/screenPkg.sv
source/screenFsm.sv
source/frameTimer.sv
source/rasterWalker.sv
source/screenSequencer.sv
bench/screenSequencerTb.sv

/* bench/screenSequencerTb.sv */
module screenSequencerTb;

	// Small frame and short display time
	localparam int frameWidth = 8;
	localparam int frameHeight = 6;
	localparam int tickCycles = 80;
	localparam int framePixels = frameWidth * frameHeight;
	// First plots of consecutive screens
	localparam int period = tickCycles + 1;
	localparam int driveDelay = 5;
	localparam int waitLimit = 1000;

	logic clk = 1'b0;
	logic rstN;
	logic cont;
	screenPkg::pixelT pixel;
	logic plot;

	int errorCount;
	int testCount;
	int cycle;
	logic [31:0] lfsr;

	// Reference model state
	int refImage;
	screenPkg::phaseT refPhase;
	int refPixel;
	int refCount;
	logic refTick;
	logic refPress;

	// Frame starts seen on the pixel port
	int startCycle[$];
	int startImage[$];
	logic lastPlot;

	screenSequencer #(
		.frameWidth(frameWidth),
		.frameHeight(frameHeight),
		.tickCycles(tickCycles)
	) i_dut (
		.clk(clk),
		.rstN(rstN),
		.cont(cont),
		.pixel(pixel),
		.plot(plot)
	);

	always #20 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// Title loop 0, 1, 2 and scene 13, 14
	function automatic int followImage(input int image);
		case (image)
			screenPkg::titleImage0: return screenPkg::titleImage1;
			screenPkg::titleImage1: return screenPkg::titleImage2;
			screenPkg::titleImage2: return screenPkg::titleImage0;
			screenPkg::sceneImage0: return screenPkg::sceneImage1;
			default: return screenPkg::sceneImage0;
		endcase
	endfunction

	task automatic takeBits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsrStep(lfsr);
			value = (value << 1) | lfsr[0];
		end
	endtask

	task automatic reportMismatch(input string name, input int expected, input int actual);
		$display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		errorCount++;
	endtask

	task automatic reportTimeout(input string what);
		$display("Timed out at %0t waiting for %s", $time, what);
		errorCount++;
	endtask

	// Inputs change a little after the rising edge
	task automatic nextDrive();
		@(posedge clk);
		#driveDelay;
	endtask

	task automatic waitStarts(input int target);
		int waited;
		waited = 0;
		while (startCycle.size() < target && waited < waitLimit) begin
			nextDrive();
			waited++;
		end
		if (startCycle.size() < target) begin
			reportTimeout("a new frame on the pixel port");
		end
	endtask

	task automatic waitPlotLow();
		int waited;
		waited = 0;
		while (plot && waited < waitLimit) begin
			nextDrive();
			waited++;
		end
		if (plot) begin
			reportTimeout("the end of a frame");
		end
	endtask

	// One press held for a single clock
	task automatic pressButton();
		cont = 1'b1;
		nextDrive();
		cont = 1'b0;
	endtask

	// Image order and spacing of recorded frame starts
	task automatic checkSequence(input int from, input int count, input int firstImage);
		int expected;
		if (from + count > startCycle.size()) begin
			$display("Too few frames recorded to check the screen order");
			errorCount++;
			return;
		end
		expected = firstImage;
		for (int i = 0; i < count; i++) begin
			assert (startImage[from + i] == expected)
				else reportMismatch("pixel.image", expected, startImage[from + i]);
			if (i > 0) begin
				assert (startCycle[from + i] - startCycle[from + i - 1] == period)
					else reportMismatch("frame period", period,
						startCycle[from + i] - startCycle[from + i - 1]);
			end
			expected = followImage(expected);
		end
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) begin
			$display("Test %0d %s: ok", testCount, name);
		end else begin
			$display("Test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
		end
	endtask

	// Reference model, one step per clock
	always @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			refImage = screenPkg::titleImage0;
			refPhase = screenPkg::phaseLoad;
			refPixel = 0;
			refCount = 0;
		end else begin
			refTick = (refCount == tickCycles - 1);
			refPress = cont && (refImage < screenPkg::sceneImage0) &&
				((refPhase == screenPkg::phaseDraw) || (refPhase == screenPkg::phaseHold));
			// Timer starts from zero after Load and stops at its limit
			if (refPhase == screenPkg::phaseLoad) begin
				refCount = 0;
			end else if (!refTick) begin
				refCount++;
			end
			if (refPress) begin
				refImage = screenPkg::sceneImage0;
				refPhase = screenPkg::phaseLoad;
			end else begin
				case (refPhase)
					screenPkg::phaseLoad: refPhase = screenPkg::phaseClear;
					screenPkg::phaseClear: begin
						refPhase = screenPkg::phaseDraw;
						refPixel = 0;
					end
					screenPkg::phaseDraw: begin
						if (refPixel == framePixels - 1) begin
							refPhase = screenPkg::phaseHold;
						end else begin
							refPixel++;
						end
					end
					default: begin
						if (refTick) begin
							refImage = followImage(refImage);
							refPhase = screenPkg::phaseLoad;
						end
					end
				endcase
			end
		end
	end

	// Pixel port checked mid-cycle against the model
	always @(negedge clk) begin
		cycle++;
		if (!rstN) begin
			assert (!plot) else reportMismatch("plot", 0, plot);
		end else begin
			assert (plot == (refPhase == screenPkg::phaseDraw))
				else reportMismatch("plot", refPhase == screenPkg::phaseDraw, plot);
			if (plot) begin
				assert (pixel.address == refPixel)
					else reportMismatch("pixel.address", refPixel, pixel.address);
				assert (pixel.x == refPixel % frameWidth)
					else reportMismatch("pixel.x", refPixel % frameWidth, pixel.x);
				assert (pixel.y == refPixel / frameWidth)
					else reportMismatch("pixel.y", refPixel / frameWidth, pixel.y);
				assert (pixel.image == refImage)
					else reportMismatch("pixel.image", refImage, pixel.image);
				// First pixel of a frame
				if (!lastPlot) begin
					startCycle.push_back(cycle);
					startImage.push_back(pixel.image);
				end
			end
		end
		lastPlot = plot;
	end

	initial begin
		int errorsBefore;
		int first;
		int value;
		rstN = 1'b0;
		cont = 1'b0;
		errorCount = 0;
		testCount = 0;
		cycle = 0;
		lastPlot = 1'b0;
		lfsr = 32'hdd18;

		errorsBefore = errorCount;
		repeat (4) begin
			nextDrive();
			assert (!plot) else reportMismatch("plot", 0, plot);
		end
		rstN = 1'b1;
		// Load and Clear cycles
		assert (!plot) else reportMismatch("plot", 0, plot);
		nextDrive();
		assert (!plot) else reportMismatch("plot", 0, plot);
		finishTest("reset", errorsBefore);

		errorsBefore = errorCount;
		waitStarts(1);
		waitPlotLow();
		finishTest("frame contents", errorsBefore);

		errorsBefore = errorCount;
		waitStarts(4);
		checkSequence(0, 4, screenPkg::titleImage0);
		finishTest("title loop", errorsBefore);

		// Random number of frames, then a press while drawing or holding
		errorsBefore = errorCount;
		takeBits(2, value);
		waitStarts(startCycle.size() + value + 1);
		takeBits(6, value);
		repeat (value) nextDrive();
		pressButton();
		first = startCycle.size();
		waitStarts(first + 4);
		checkSequence(first, 4, screenPkg::sceneImage0);
		finishTest("scene entry", errorsBefore);

		// Presses at any offset inside the scene
		// Fourth scene frame so far shows the second scene image
		errorsBefore = errorCount;
		first = startCycle.size() - 1;
		repeat (3) begin
			waitStarts(startCycle.size() + 1);
			takeBits(7, value);
			repeat (value % period) nextDrive();
			pressButton();
		end
		waitStarts(startCycle.size() + 2);
		checkSequence(first, startCycle.size() - first, screenPkg::sceneImage1);
		finishTest("button in scene", errorsBefore);

		// Reset while plot is high
		errorsBefore = errorCount;
		waitStarts(startCycle.size() + 1);
		takeBits(5, value);
		repeat (value) nextDrive();
		assert (plot) else reportMismatch("plot", 1, plot);
		rstN = 1'b0;
		#1;
		assert (!plot) else reportMismatch("plot", 0, plot);
		repeat (4) nextDrive();
		rstN = 1'b1;
		first = startCycle.size();
		waitStarts(first + 2);
		checkSequence(first, 2, screenPkg::titleImage0);
		finishTest("reset mid-frame", errorsBefore);

		$display("Tests run %0d, errors %0d", testCount, errorCount);
		if (errorCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* source/screenSequencer.sv */
module screenSequencer #(
	// Frame size in pixels
	parameter int frameWidth = 160,
	parameter int frameHeight = 120,
	// 4 Hz at 50 MHz
	parameter int tickCycles = 12500000
) (
	input logic clk,
	input logic rstN,
	// Continue button
	input logic cont,
	// Pixel to the VGA framebuffer adapter
	output screenPkg::pixelT pixel,
	// Pixel strobe, one write per cycle
	output logic plot
);

	// FSM and walker
	screenPkg::rasterCtrlT rasterCtrl;
	logic lastPixel;

	// FSM and timer
	logic restart;
	logic tick;

	// Pixel fields
	screenPkg::imageIdT image;
	screenPkg::xCoordT walkX;
	screenPkg::yCoordT walkY;
	screenPkg::pixelAddrT walkAddress;

	screenFsm i_screenFsm (
		.clk(clk),
		.rstN(rstN),
		.cont(cont),
		.lastPixel(lastPixel),
		.tick(tick),
		.rasterCtrl(rasterCtrl),
		.restart(restart),
		.plot(plot),
		.image(image)
	);

	frameTimer #(.tickCycles(tickCycles)) i_frameTimer (
		.clk(clk),
		.rstN(rstN),
		.restart(restart),
		.tick(tick)
	);

	rasterWalker #(.frameWidth(frameWidth), .frameHeight(frameHeight)) i_rasterWalker (
		.clk(clk),
		.rstN(rstN),
		.rasterCtrl(rasterCtrl),
		.x(walkX),
		.y(walkY),
		.address(walkAddress),
		.lastPixel(lastPixel)
	);

	// Walker position plus the image of the current screen
	assign pixel = '{x: walkX, y: walkY, address: walkAddress, image: image};

endmodule

/* source/rasterWalker.sv */
module rasterWalker #(
	parameter int frameWidth = 160,
	parameter int frameHeight = 120
) (
	input logic clk,
	input logic rstN,
	// Clear to origin or step one pixel
	input screenPkg::rasterCtrlT rasterCtrl,
	output screenPkg::xCoordT x,
	output screenPkg::yCoordT y,
	output screenPkg::pixelAddrT address,
	// High while on the bottom-right pixel
	output logic lastPixel
);

	// Final column and row of the frame
	localparam screenPkg::xCoordT lastX = screenPkg::xCoordT'(frameWidth - 1);
	localparam screenPkg::yCoordT lastY = screenPkg::yCoordT'(frameHeight - 1);

	// Edge decodes
	logic lastColumn;
	logic lastRow;

	assign lastColumn = (x == lastX);
	assign lastRow = (y == lastY);
	assign lastPixel = lastColumn && lastRow;

	// Column counter
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			x <= '0;
		end else if (rasterCtrl.clear) begin
			x <= '0;
		end else if (rasterCtrl.step) begin
			// Wrap at the right edge
			if (lastColumn) begin
				x <= '0;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	// Row counter, moves when the column wraps
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			y <= '0;
		end else if (rasterCtrl.clear) begin
			y <= '0;
		end else if (rasterCtrl.step && lastColumn) begin
			// Back to the top after the last row
			if (lastRow) begin
				y <= '0;
			end else begin
				y <= y + 1'b1;
			end
		end
	end

	// Linear address kept in step with x and y
	// Saves a multiplier on row * width
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			address <= '0;
		end else if (rasterCtrl.clear) begin
			address <= '0;
		end else if (rasterCtrl.step) begin
			if (lastPixel) begin
				address <= '0;
			end else begin
				address <= address + 1'b1;
			end
		end
	end

endmodule

/* source/frameTimer.sv */
module frameTimer #(
	// Clock cycles per displayed screen
	parameter int tickCycles = 12500000
) (
	input logic clk,
	input logic rstN,
	// Start a new count
	input logic restart,
	// Sticky until the next restart
	output logic tick
);

	// Count where the tick is raised
	localparam screenPkg::tickCountT lastCount = screenPkg::tickCountT'(tickCycles - 1);

	// Cycles since the last restart
	screenPkg::tickCountT count;

	// Holds at the limit so the tick stays up
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			count <= '0;
		end else if (restart) begin
			count <= '0;
		end else if (count != lastCount) begin
			count <= count + 1'b1;
		end
	end

	assign tick = (count == lastCount);

endmodule

/* source/screenFsm.sv */
module screenFsm (
	input logic clk,
	input logic rstN,
	// Continue button, sampled every clock
	input logic cont,
	// Walker sits on the bottom-right pixel
	input logic lastPixel,
	// Display time of the screen has elapsed
	input logic tick,
	output screenPkg::rasterCtrlT rasterCtrl,
	output logic restart,
	output logic plot,
	output screenPkg::imageIdT image
);

	// Current screen and phase
	screenPkg::screenT screen;
	screenPkg::phaseT phase;

	// Next values
	screenPkg::screenT screenNext;
	screenPkg::phaseT phaseNext;

	// Screen that follows on a tick
	screenPkg::screenT followScreen;

	// Title screens only
	logic isTitle;

	// Button press that leaves the title loop
	logic contTaken;

	// State registers
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			screen <= screenPkg::titleOne;
			phase <= screenPkg::phaseLoad;
		end else begin
			screen <= screenNext;
			phase <= phaseNext;
		end
	end

	// Title loop wraps 1 -> 2 -> 3 -> 1
	// Scene alternates between its two images
	always_comb begin
		case (screen)
			screenPkg::titleOne: begin
				followScreen = screenPkg::titleTwo;
			end
			screenPkg::titleTwo: begin
				followScreen = screenPkg::titleThree;
			end
			screenPkg::titleThree: begin
				followScreen = screenPkg::titleOne;
			end
			screenPkg::sceneOne: begin
				followScreen = screenPkg::sceneTwo;
			end
			screenPkg::sceneTwo: begin
				followScreen = screenPkg::sceneOne;
			end
			default: begin
				followScreen = screenPkg::titleOne;
			end
		endcase
	end

	assign isTitle = (screen == screenPkg::titleOne) ||
		(screen == screenPkg::titleTwo) ||
		(screen == screenPkg::titleThree);

	// Button only counts once the frame has started drawing
	assign contTaken = cont && isTitle &&
		((phase == screenPkg::phaseDraw) || (phase == screenPkg::phaseHold));

	// Next screen and phase
	always_comb begin
		screenNext = screen;
		phaseNext = phase;
		case (phase)
			// One cycle to pick the image and restart the timer
			screenPkg::phaseLoad: begin
				phaseNext = screenPkg::phaseClear;
			end
			// One cycle to put the walker at the origin
			screenPkg::phaseClear: begin
				phaseNext = screenPkg::phaseDraw;
			end
			// Stop after the bottom-right pixel is written
			screenPkg::phaseDraw: begin
				if (lastPixel) begin
					phaseNext = screenPkg::phaseHold;
				end
			end
			// Wait for the frame tick, then load the next screen
			screenPkg::phaseHold: begin
				if (tick) begin
					screenNext = followScreen;
					phaseNext = screenPkg::phaseLoad;
				end
			end
			default: begin
				phaseNext = screenPkg::phaseLoad;
			end
		endcase

		// Button wins over the frame and the tick
		if (contTaken) begin
			screenNext = screenPkg::sceneOne;
			phaseNext = screenPkg::phaseLoad;
		end
	end

	// Phase decode
	always_comb begin
		restart = 1'b0;
		rasterCtrl = '0;
		plot = 1'b0;
		case (phase)
			screenPkg::phaseLoad: begin
				restart = 1'b1;
			end
			screenPkg::phaseClear: begin
				rasterCtrl.clear = 1'b1;
			end
			// One pixel per clock
			screenPkg::phaseDraw: begin
				rasterCtrl.step = 1'b1;
				plot = 1'b1;
			end
			default: begin
				restart = 1'b0;
			end
		endcase
	end

	// Image number per screen
	always_comb begin
		case (screen)
			screenPkg::titleOne: begin
				image = screenPkg::titleImage0;
			end
			screenPkg::titleTwo: begin
				image = screenPkg::titleImage1;
			end
			screenPkg::titleThree: begin
				image = screenPkg::titleImage2;
			end
			screenPkg::sceneOne: begin
				image = screenPkg::sceneImage0;
			end
			screenPkg::sceneTwo: begin
				image = screenPkg::sceneImage1;
			end
			default: begin
				image = screenPkg::titleImage0;
			end
		endcase
	end

endmodule

/* source/screenPkg.sv */
package screenPkg;

	// Pixel column, frame is at most 160 wide
	typedef logic [7:0] xCoordT;

	// Pixel row, at most 120 rows
	typedef logic [6:0] yCoordT;

	// Linear framebuffer address, row * width + column
	typedef logic [14:0] pixelAddrT;

	// Stored image the framebuffer adapter reads colour from
	typedef logic [4:0] imageIdT;

	// Frame timer count, enough for a 4 Hz tick at 50 MHz
	typedef logic [23:0] tickCountT;

	// Title images
	localparam imageIdT titleImage0 = 5'd0;
	localparam imageIdT titleImage1 = 5'd1;
	localparam imageIdT titleImage2 = 5'd2;

	// Cat and dog scene images
	localparam imageIdT sceneImage0 = 5'd13;
	localparam imageIdT sceneImage1 = 5'd14;

	// Which screen is shown
	typedef enum logic [2:0] {
		titleOne,
		titleTwo,
		titleThree,
		sceneOne,
		sceneTwo
	} screenT;

	// Steps within one screen
	typedef enum logic [1:0] {
		phaseLoad,
		phaseClear,
		phaseDraw,
		phaseHold
	} phaseT;

	// FSM to raster walker
	typedef struct packed {
		logic clear;
		logic step;
	} rasterCtrlT;

	// One pixel to the framebuffer adapter
	typedef struct packed {
		xCoordT x;
		yCoordT y;
		pixelAddrT address;
		imageIdT image;
	} pixelT;

endpackage
